// File: rtl/dir_pkg.sv
//////////////////////////////////////////////////
// L2 directory package
// Widths, opcodes and the request and read data
// structs shared by every directory block
//////////////////////////////////////////////////

package dir_pkg;

   //////////////////////////////////////////////////
   // Directory geometry
   //////////////////////////////////////////////////

   localparam int DIR_TAG_W   = 30;   // Stored address tag
   localparam int DIR_ENTRIES = 64;   // Entries per panel
   localparam int DIR_ADDR_W  = 6;    // Entry address
   localparam int DIR_HIT_W   = 32;   // One hit per even/odd pair
   localparam int DIR_MASK_W  = 8;    // Invalidate groups of 8 entries
   localparam int DIR_PANELS  = 4;

   //////////////////////////////////////////////////
   // Panel operations
   //////////////////////////////////////////////////

   // One opcode per panel per cycle
   typedef enum logic [1:0] {
      DIR_NOP    = 2'd0,
      DIR_READ   = 2'd1,
      DIR_WRITE  = 2'd2,
      DIR_LOOKUP = 2'd3
   } dir_op_e;

   // Write entry or lookup key
   // On a lookup, tag and odd form the key and parity/valid are unused
   typedef struct packed {
      logic [DIR_TAG_W-1:0] tag;
      logic                 odd;      // Even or odd entry of a pair
      logic                 parity;
      logic                 valid;
   } dir_entry_t;

   // One panel request
   typedef struct packed {
      dir_op_e                 op;
      logic [DIR_ADDR_W-1:0]   addr;
      dir_entry_t              data;
      logic [DIR_MASK_W-1:0]   inv_mask;
   } dir_req_t;

   // Read data returned per panel
   typedef struct packed {
      logic [DIR_TAG_W-1:0] tag;
      logic                 parity;
      logic                 valid;
   } dir_rd_t;

endpackage

// File: rtl/dir_tag_array.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Directory tag array
// Tag, parity and valid storage of one panel with
// read, write, lookup invalidate and warm clear
//////////////////////////////////////////////////

module dir_tag_array (
   input  logic                                   rclk,
   input  logic                                   rst_l,
   input  dir_pkg::dir_op_e                       op,
   input  logic [dir_pkg::DIR_ADDR_W-1:0]         addr,
   input  dir_pkg::dir_entry_t                    data,
   input  logic                                   warm_clr,
   input  logic [dir_pkg::DIR_ENTRIES-1:0]        inval,
   output logic [dir_pkg::DIR_ENTRIES-1:0][dir_pkg::DIR_TAG_W-1:0] tags,
   output logic [dir_pkg::DIR_ENTRIES-1:0]        valid,
   output dir_pkg::dir_rd_t                       rd
);

   logic [dir_pkg::DIR_ENTRIES-1:0] par_mem;

   //////////////////////////////////////////////////
   // Tag and parity storage
   //////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (rst_l && op == dir_pkg::DIR_WRITE) begin
         tags[addr]    <= data.tag;
         par_mem[addr] <= data.parity;
      end
   end

   //////////////////////////////////////////////////
   // Valid bits
   //////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (!rst_l) begin
         valid <= '0;
      end else if (warm_clr) begin
         valid <= '0;                     // Wins over write and invalidate
      end else begin
         valid <= valid & ~inval;         // Lookup invalidate
         if (op == dir_pkg::DIR_WRITE) begin
            valid[addr] <= data.valid;
         end
      end
   end

   // Read port, write data flows through
   always_ff @(posedge rclk) begin
      if (!rst_l) begin
         rd <= '0;
      end else begin
         case (op)
            dir_pkg::DIR_READ: begin
               rd.tag    <= tags[addr];
               rd.parity <= par_mem[addr];
               rd.valid  <= valid[addr];
            end
            dir_pkg::DIR_WRITE: begin
               rd.tag    <= data.tag;
               rd.parity <= data.parity;
               rd.valid  <= data.valid;
            end
            default: begin
               rd <= rd;                  // Hold through NOP and lookup
            end
         endcase
      end
   end

   // Matcher must only invalidate entries that are currently valid
   a_inval_on_valid: assert property (
      @(posedge rclk) disable iff (!rst_l)
      (inval & ~valid) == '0
   ) else $error("dir_tag_array: inval marks an invalid entry");

endmodule

// File: rtl/dir_match.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Directory tag matcher
// Compares a lookup key with all entries of a
// panel, returns pair hits and the invalidate set
//////////////////////////////////////////////////

module dir_match (
   input  dir_pkg::dir_entry_t                    key,
   input  logic                                   lookup,
   input  logic [dir_pkg::DIR_MASK_W-1:0]         inv_mask,
   input  logic [dir_pkg::DIR_ENTRIES-1:0][dir_pkg::DIR_TAG_W-1:0] tags,
   input  logic [dir_pkg::DIR_ENTRIES-1:0]        valid,
   output logic [dir_pkg::DIR_HIT_W-1:0]          hit,
   output logic [dir_pkg::DIR_ENTRIES-1:0]        inval
);

   localparam int GROUP = dir_pkg::DIR_ENTRIES / dir_pkg::DIR_MASK_W;

   logic [dir_pkg::DIR_ENTRIES-1:0] match;

   // Per entry compare
   // Key odd bit picks which entry of the pair may match
   always_comb begin
      for (int i = 0; i < dir_pkg::DIR_ENTRIES; i++) begin
         match[i] = lookup && valid[i] &&
                    (tags[i] == key.tag) &&
                    (key.odd == i[0]);
      end
   end

   // Pair hits
   always_comb begin
      for (int j = 0; j < dir_pkg::DIR_HIT_W; j++) begin
         hit[j] = match[2*j] | match[2*j+1];
      end
   end

   // Invalidate set from one mask bit per group of entries
   always_comb begin
      for (int i = 0; i < dir_pkg::DIR_ENTRIES; i++) begin
         inval[i] = match[i] & inv_mask[i / GROUP];
      end
   end

endmodule

// File: rtl/dir_cam_panel.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Directory CAM panel
// Request stage, tag array, matcher and the
// registered pair hit vector of one panel
//////////////////////////////////////////////////

module dir_cam_panel (
   input  logic                          rclk,
   input  logic                          rst_l,
   input  dir_pkg::dir_req_t             req,
   input  logic                          warm_clr,
   output logic [dir_pkg::DIR_HIT_W-1:0] hit,
   output dir_pkg::dir_rd_t              rd
);

   dir_pkg::dir_req_t                                       req_q;
   logic                                                    lookup;
   logic [dir_pkg::DIR_HIT_W-1:0]                           match_hit;
   logic [dir_pkg::DIR_ENTRIES-1:0]                         inval;
   logic [dir_pkg::DIR_ENTRIES-1:0]                         valid;
   logic [dir_pkg::DIR_ENTRIES-1:0][dir_pkg::DIR_TAG_W-1:0] tags;

   //////////////////////////////////////////////////
   // Request stage
   //////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (!rst_l) begin
         req_q    <= req;
         req_q.op <= dir_pkg::DIR_NOP;    // Stage holds a NOP
      end else begin
         req_q    <= req;
      end
   end

   assign lookup = (req_q.op == dir_pkg::DIR_LOOKUP);

   // Hit register is zero unless a lookup was staged
   always_ff @(posedge rclk) begin
      if (!rst_l) begin
         hit <= '0;
      end else begin
         hit <= match_hit;
      end
   end

   dir_tag_array u_array (
      .rclk     (rclk),
      .rst_l    (rst_l),
      .op       (req_q.op),
      .addr     (req_q.addr),
      .data     (req_q.data),
      .warm_clr (warm_clr),
      .inval    (inval),
      .tags     (tags),
      .valid    (valid),
      .rd       (rd)
   );

   dir_match u_match (
      .key      (req_q.data),
      .lookup   (lookup),
      .inv_mask (req_q.inv_mask),
      .tags     (tags),
      .valid    (valid),
      .hit      (match_hit),
      .inval    (inval)
   );

endmodule

// File: rtl/dir_panel_pair.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Directory panel pair
// Two panels with a shared registered warm reset
//////////////////////////////////////////////////

module dir_panel_pair (
   input  logic                          rclk,
   input  logic                          rst_l,
   input  logic                          warm_rst,
   input  dir_pkg::dir_req_t             req0,
   input  dir_pkg::dir_req_t             req1,
   output logic [dir_pkg::DIR_HIT_W-1:0] pair_hit,
   output dir_pkg::dir_rd_t              rd0,
   output dir_pkg::dir_rd_t              rd1
);

   logic                          warm_clr;
   logic [dir_pkg::DIR_HIT_W-1:0] hit0;
   logic [dir_pkg::DIR_HIT_W-1:0] hit1;

   // Warm reset acts one edge after sampling
   always_ff @(posedge rclk) begin
      if (!rst_l) begin
         warm_clr <= 1'b0;
      end else begin
         warm_clr <= warm_rst;
      end
   end

   dir_cam_panel u_panel0 (
      .rclk     (rclk),
      .rst_l    (rst_l),
      .req      (req0),
      .warm_clr (warm_clr),
      .hit      (hit0),
      .rd       (rd0)
   );

   dir_cam_panel u_panel1 (
      .rclk     (rclk),
      .rst_l    (rst_l),
      .req      (req1),
      .warm_clr (warm_clr),
      .hit      (hit1),
      .rd       (rd1)
   );

   assign pair_hit = hit0 | hit1;

endmodule

// File: rtl/dir_top.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// L2 directory top
// Four tag CAM panels in two pairs, hits ORed
// into one row hit vector
//////////////////////////////////////////////////

module dir_top (
   input  logic                                           rclk,
   input  logic                                           rst_l,
   input  logic                                           warm_rst,
   input  dir_pkg::dir_req_t [dir_pkg::DIR_PANELS-1:0]    req,
   output logic [dir_pkg::DIR_HIT_W-1:0]                  row_hit,
   output dir_pkg::dir_rd_t [dir_pkg::DIR_PANELS-1:0]     rd
);

   logic [dir_pkg::DIR_HIT_W-1:0] pair_hit0;   // Panels 0 and 1
   logic [dir_pkg::DIR_HIT_W-1:0] pair_hit1;   // Panels 2 and 3

   dir_panel_pair u_pair0 (
      .rclk     (rclk),
      .rst_l    (rst_l),
      .warm_rst (warm_rst),
      .req0     (req[0]),
      .req1     (req[1]),
      .pair_hit (pair_hit0),
      .rd0      (rd[0]),
      .rd1      (rd[1])
   );

   dir_panel_pair u_pair1 (
      .rclk     (rclk),
      .rst_l    (rst_l),
      .warm_rst (warm_rst),
      .req0     (req[2]),
      .req1     (req[3]),
      .pair_hit (pair_hit1),
      .rd0      (rd[2]),
      .rd1      (rd[3])
   );

   // Row hit over all panels
   assign row_hit = pair_hit0 | pair_hit1;

endmodule

// File: dv/dir_model.svh
//////////////////////////////////////////////////
// Directory reference model
// Tags, parity and valid bits of all four panels,
// the staged requests and the expected outputs
//////////////////////////////////////////////////
`ifndef DIR_MODEL_SVH
`define DIR_MODEL_SVH

logic [dir_pkg::DIR_TAG_W-1:0]   mem_tag [dir_pkg::DIR_PANELS][dir_pkg::DIR_ENTRIES];
logic                            mem_par [dir_pkg::DIR_PANELS][dir_pkg::DIR_ENTRIES];
logic [dir_pkg::DIR_ENTRIES-1:0] mem_vld [dir_pkg::DIR_PANELS];
dir_pkg::dir_req_t               staged  [dir_pkg::DIR_PANELS];   // Captured last edge
dir_pkg::dir_rd_t                exp_rd  [dir_pkg::DIR_PANELS];
logic [dir_pkg::DIR_HIT_W-1:0]   exp_hit;
logic                            warm_q;                          // Registered warm reset

// Edge with rst_l low, tags keep their contents
function automatic void clear_state();
   for (int p = 0; p < dir_pkg::DIR_PANELS; p++) begin
      mem_vld[p]   = '0;
      exp_rd[p]    = '0;
      staged[p]    = '0;
      staged[p].op = dir_pkg::DIR_NOP;
   end
   exp_hit = '0;
   warm_q  = 1'b0;
endfunction

// One rising edge with rst_l high
function automatic void apply_edge(
   input dir_pkg::dir_req_t [dir_pkg::DIR_PANELS-1:0] req_in,
   input logic                                         warm_in
);
   dir_pkg::dir_req_t               r;
   logic [dir_pkg::DIR_ENTRIES-1:0] old_vld;
   logic [dir_pkg::DIR_ENTRIES-1:0] kill;
   logic                            m;
   exp_hit = '0;
   for (int p = 0; p < dir_pkg::DIR_PANELS; p++) begin
      r       = staged[p];
      old_vld = mem_vld[p];
      kill    = '0;
      // Lookup sees valid bits from before this edge
      if (r.op == dir_pkg::DIR_LOOKUP) begin
         for (int i = 0; i < dir_pkg::DIR_ENTRIES; i++) begin
            m = old_vld[i] && (mem_tag[p][i] == r.data.tag) &&
                (r.data.odd == (i % 2 == 1));
            if (m) begin
               exp_hit[i / 2] = 1'b1;
               kill[i]        = r.inv_mask[i / 8];   // Group of eight entries
            end
         end
      end
      if (r.op == dir_pkg::DIR_READ) begin
         exp_rd[p].tag    = mem_tag[p][r.addr];
         exp_rd[p].parity = mem_par[p][r.addr];
         exp_rd[p].valid  = old_vld[r.addr];
      end else if (r.op == dir_pkg::DIR_WRITE) begin
         exp_rd[p].tag         = r.data.tag;          // Echo of the written entry
         exp_rd[p].parity      = r.data.parity;
         exp_rd[p].valid       = r.data.valid;
         mem_tag[p][r.addr]    = r.data.tag;
         mem_par[p][r.addr]    = r.data.parity;
      end
      if (warm_q) begin
         mem_vld[p] = '0;
      end else begin
         mem_vld[p] = old_vld & ~kill;
         if (r.op == dir_pkg::DIR_WRITE) begin
            mem_vld[p][r.addr] = r.data.valid;
         end
      end
      staged[p] = req_in[p];
   end
   warm_q = warm_in;
endfunction

`endif

// File: dv/dir_tb.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// L2 directory testbench
// Random requests on all four panels, checked
// every cycle against the reference model
//////////////////////////////////////////////////

module dir_tb;

   localparam int FILL        = dir_pkg::DIR_ENTRIES;   // One write per entry first
   localparam int RAND_CYCLES = 2000;
   localparam int DRAIN       = 3;
   localparam int TOTAL       = FILL + RAND_CYCLES + DRAIN;
   localparam int RST_WAIT    = 10;

   logic                                        rclk;
   logic                                        rst_l;
   logic                                        warm_rst;
   dir_pkg::dir_req_t [dir_pkg::DIR_PANELS-1:0] req;
   logic [dir_pkg::DIR_HIT_W-1:0]               row_hit;
   dir_pkg::dir_rd_t [dir_pkg::DIR_PANELS-1:0]  rd;

   integer                        seed;
   int                            errors;
   int                            checks;
   logic [dir_pkg::DIR_TAG_W-1:0] tag_pool [8];   // Few tags so lookups hit

`include "dir_model.svh"

   dir_top u_dir_top (
      .rclk     (rclk),
      .rst_l    (rst_l),
      .warm_rst (warm_rst),
      .req      (req),
      .row_hit  (row_hit),
      .rd       (rd)
   );

   initial begin
      rclk = 1'b0;
      forever #4 rclk = ~rclk;
   end

   initial begin
      rst_l = 1'b0;
      repeat (2) @(posedge rclk);
      #1;
      rst_l = 1'b1;
   end

   // Model follows every edge
   always @(posedge rclk) begin
      if (!rst_l) begin
         clear_state();
      end else begin
         apply_edge(req, warm_rst);
      end
   end

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_outputs();
      check_value("row_hit", row_hit, exp_hit);
      for (int p = 0; p < dir_pkg::DIR_PANELS; p++) begin
         check_value($sformatf("rd[%0d]", p), rd[p], exp_rd[p]);
      end
   endtask

   // Sampled at the edge, rst_l moves 1 ns later
   task automatic wait_reset_release(output logic ok);
      int n;
      n = 0;
      while (rst_l !== 1'b1 && n < RST_WAIT) begin
         @(posedge rclk);
         n++;
      end
      ok = (rst_l === 1'b1);
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   task automatic drive_inputs(input int cyc);
      logic [31:0] r;
      for (int p = 0; p < dir_pkg::DIR_PANELS; p++) begin
         r = $random(seed);
         req[p].inv_mask    = r[7:0];
         req[p].data.odd    = r[8];
         req[p].data.parity = r[9];
         req[p].data.valid  = (r[12:10] != 3'd0);   // Mostly valid
         req[p].data.tag    = tag_pool[r[15:13]];
         req[p].addr        = r[21:16];
         req[p].op          = dir_pkg::dir_op_e'(r[23:22]);
         if (cyc < FILL) begin
            req[p].op   = dir_pkg::DIR_WRITE;
            req[p].addr = cyc[5:0];
         end else if (cyc >= FILL + RAND_CYCLES) begin
            req[p].op = dir_pkg::DIR_NOP;
         end
      end
      r = $random(seed);
      warm_rst = (cyc >= FILL) && (cyc < FILL + RAND_CYCLES) && (r[5:0] == 6'd0);
   endtask

   task automatic run_cycles();
      for (int c = 0; c < TOTAL; c++) begin
         #1;
         check_outputs();
         drive_inputs(c);
         @(posedge rclk);
      end
      #1;
      check_outputs();
   endtask

   initial begin : main
      logic ok;
      seed     = 94;
      errors   = 0;
      checks   = 0;
      warm_rst = 1'b0;
      req      = '0;
      for (int i = 0; i < 8; i++) begin
         tag_pool[i] = 30'($random(seed));
      end
      wait_reset_release(ok);
      if (!ok) begin
         $display("reset release not seen within %0d cycles", RST_WAIT);
         $display("Test failed");
      end else begin
         run_cycles();
         $display("checks %0d errors %0d", checks, errors);
         if (errors == 0) begin
            $display("Test passed");
         end else begin
            $display("Test failed");
         end
      end
      $finish;
   end

endmodule

// File: sources.f
+incdir+dv
rtl/dir_pkg.sv
rtl/dir_tag_array.sv
rtl/dir_match.sv
rtl/dir_cam_panel.sv
rtl/dir_panel_pair.sv
rtl/dir_top.sv
dv/dir_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the directory testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module dir_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vdir_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# Result comes from the log
if grep -q "Test failed" "$LOG"; then
   exit 1
fi
exit 0
